// ==== design/bus_fabric.sv ====
`default_nettype none

module bus_fabric
    import platform_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  bus_req_t    req_i,
    input  logic [31:0] rtc_rdata_i,
    input  logic [31:0] plic_rdata_i,
    input  logic [31:0] periph_rdata_i,
    output logic        rtc_en_o,
    output logic        plic_en_o,
    output logic        periph_en_o,
    output logic [31:0] rdata_o
);

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_RTC,
        SEL_PLIC,
        SEL_PERIPH
    } sel_e;

    logic [3:0] region;
    sel_e       sel_d;
    sel_e       sel_q;   // region of last request

    assign region = req_i.addr[31:28];

    ////////////////////
    // decode
    ////////////////////

    always_comb begin
        if (region < REGION_RTC) begin
            sel_d = SEL_RAM;
        end else if (region < REGION_PLIC_LO) begin
            sel_d = SEL_RTC;
        end else if (region < REGION_PERIPH_LO) begin
            sel_d = SEL_PLIC;
        end else begin
            sel_d = SEL_PERIPH;
        end
    end

    assign rtc_en_o    = req_i.en && (sel_d == SEL_RTC);
    assign plic_en_o   = req_i.en && (sel_d == SEL_PLIC);
    assign periph_en_o = req_i.en && (sel_d == SEL_PERIPH);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q <= SEL_RAM;
        end else if (req_i.en) begin
            sel_q <= sel_d;
        end
    end

    ////////////////////
    // read-back
    ////////////////////

    always_comb begin
        case (sel_q)
            SEL_RTC:    rdata_o = rtc_rdata_i;
            SEL_PLIC:   rdata_o = plic_rdata_i;
            SEL_PERIPH: rdata_o = periph_rdata_i;
            default:    rdata_o = '0;   // no program memory here
        endcase
    end

endmodule

`default_nettype wire

// ==== design/irq_pkg.sv ====
`default_nettype none

package irq_pkg;

    // external sources, ids 1..IRQ_CNT, 0 is none
    localparam int IRQ_CNT = 2;

    typedef logic [1:0]         irq_id_t;
    typedef logic [IRQ_CNT-1:0] irq_vec_t;   // bit i is source i+1

    // lines towards the core
    typedef struct packed {
        logic mti;   // machine timer
        logic mei;   // machine external
    } irq_lines_t;

endpackage

`default_nettype wire

// ==== design/pin_port.sv ====
`default_nettype none

module pin_port
    import platform_pkg::*, irq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 en_i,
    input  bus_req_t             req_i,
    output logic [31:0]          rdata_o,
    input  irq_vec_t             pins_i,
    output logic [PIN_OUT_W-1:0] leds_o,
    output irq_vec_t             irq_o,
    input  irq_vec_t             iack_i
);

    irq_vec_t   sync_q;    // first stage
    irq_vec_t   level_q;   // synchronized level
    irq_vec_t   prev_q;
    irq_vec_t   rise;
    logic [3:0] ofs;

    assign ofs  = req_i.addr[3:0];
    assign rise = level_q & ~prev_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q  <= '0;
            level_q <= '0;
            prev_q  <= '0;
            irq_o   <= '0;
            leds_o  <= '0;
        end else begin
            sync_q  <= pins_i;
            level_q <= sync_q;
            prev_q  <= level_q;
            irq_o   <= (irq_o & ~iack_i) | rise;   // new edge beats ack
            if (en_i && req_i.we[0] && ofs == OFS_PIN_OUT) begin
                leds_o <= req_i.wdata[PIN_OUT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (ofs)
                OFS_PIN_LEVEL: rdata_o <= 32'(level_q);
                OFS_PIN_REQ:   rdata_o <= 32'(irq_o);
                OFS_PIN_OUT:   rdata_o <= 32'(leds_o);
                default:       rdata_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/platform_pkg.sv ====
`default_nettype none

package platform_pkg;

    ////////////////////
    // bus request
    ////////////////////

    typedef struct packed {
        logic        en;     // operation strobe
        logic [3:0]  we;     // byte write strobes
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    ////////////////////
    // address map, on addr[31:28]
    ////////////////////

    localparam logic [3:0] REGION_RTC       = 4'd2;   // below this is program memory
    localparam logic [3:0] REGION_PLIC_LO   = 4'd3;
    localparam logic [3:0] REGION_PERIPH_LO = 4'd8;

    // timer registers
    localparam logic [3:0] OFS_MTIME_LO     = 4'd0;
    localparam logic [3:0] OFS_MTIME_HI     = 4'd4;
    localparam logic [3:0] OFS_MTIMECMP_LO  = 4'd8;
    localparam logic [3:0] OFS_MTIMECMP_HI  = 4'd12;

    // interrupt controller registers
    localparam logic [3:0] OFS_IRQ_ENABLE   = 4'd0;
    localparam logic [3:0] OFS_IRQ_PENDING  = 4'd4;
    localparam logic [3:0] OFS_IRQ_CLAIM    = 4'd8;

    // pin port registers
    localparam logic [3:0] OFS_PIN_LEVEL    = 4'd0;
    localparam logic [3:0] OFS_PIN_REQ      = 4'd4;
    localparam logic [3:0] OFS_PIN_OUT      = 4'd8;

    localparam int PIN_OUT_W = 4;   // led register width

endpackage

`default_nettype wire

// ==== design/platform_top.sv ====
`default_nettype none

module platform_top
    import platform_pkg::*, irq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  bus_req_t             bus_req_i,
    output logic [31:0]          bus_rdata_o,
    input  logic                 irq_ack_i,
    input  irq_vec_t             pins_i,
    output logic [PIN_OUT_W-1:0] leds_o,
    output irq_lines_t           irq_o
);

    logic        rtc_en;
    logic        plic_en;
    logic        periph_en;
    logic [31:0] rtc_rdata;
    logic [31:0] plic_rdata;
    logic [31:0] periph_rdata;
    irq_vec_t    pin_irq;    // pin port to controller
    irq_vec_t    pin_iack;   // and back
    logic        mti;
    logic        mei;

    assign irq_o = '{mti: mti, mei: mei};

    ////////////////////
    // decode and read-back
    ////////////////////

    bus_fabric u_fabric (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (bus_req_i),
        .rtc_rdata_i    (rtc_rdata),
        .plic_rdata_i   (plic_rdata),
        .periph_rdata_i (periph_rdata),
        .rtc_en_o       (rtc_en),
        .plic_en_o      (plic_en),
        .periph_en_o    (periph_en),
        .rdata_o        (bus_rdata_o)
    );

    ////////////////////
    // blocks
    ////////////////////

    rtc_timer u_rtc (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (rtc_en),
        .req_i   (bus_req_i),
        .rdata_o (rtc_rdata),
        .mti_o   (mti)
    );

    plic_gateway u_plic (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .en_i      (plic_en),
        .req_i     (bus_req_i),
        .rdata_o   (plic_rdata),
        .irq_i     (pin_irq),
        .irq_ack_i (irq_ack_i),
        .mei_o     (mei),
        .iack_o    (pin_iack)
    );

    pin_port u_pins (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (periph_en),
        .req_i   (bus_req_i),
        .rdata_o (periph_rdata),
        .pins_i  (pins_i),
        .leds_o  (leds_o),
        .irq_o   (pin_irq),
        .iack_i  (pin_iack)
    );

endmodule

`default_nettype wire

// ==== design/plic_gateway.sv ====
`default_nettype none

module plic_gateway
    import platform_pkg::*, irq_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        en_i,
    input  bus_req_t    req_i,
    output logic [31:0] rdata_o,
    input  irq_vec_t    irq_i,
    input  logic        irq_ack_i,
    output logic        mei_o,
    output irq_vec_t    iack_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_CLAIMED
    } state_e;

    state_e   state_q;
    state_e   state_d;
    irq_vec_t irq_en;     // enable mask
    irq_vec_t active;     // enabled and pending
    irq_id_t  claim_id;
    irq_id_t  next_id;
    logic [3:0] ofs;
    logic     complete;

    assign ofs      = req_i.addr[3:0];
    assign active   = irq_i & irq_en;
    assign complete = en_i && (req_i.we != '0) && (ofs == OFS_IRQ_CLAIM)
                      && (req_i.wdata == 32'(claim_id));

    // lowest source number wins
    always_comb begin
        next_id = '0;
        for (int i = IRQ_CNT - 1; i >= 0; i--) begin
            if (active[i]) begin
                next_id = irq_id_t'(i + 1);
            end
        end
    end

    ////////////////////
    // claim fsm
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (irq_ack_i && next_id != '0) state_d = ST_ACK;
            ST_ACK:     state_d = ST_CLAIMED;
            ST_CLAIMED: if (complete) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            claim_id <= '0;
            irq_en   <= '0;
            mei_o    <= 1'b0;
        end else begin
            state_q <= state_d;
            mei_o   <= (active != '0) && (state_d == ST_IDLE);   // masked while claimed
            if (state_q == ST_IDLE && state_d == ST_ACK) begin
                claim_id <= next_id;
            end else if (state_q == ST_CLAIMED && state_d == ST_IDLE) begin
                claim_id <= '0;
            end
            if (en_i && req_i.we[0] && ofs == OFS_IRQ_ENABLE) begin
                irq_en <= req_i.wdata[IRQ_CNT-1:0];
            end
        end
    end

    // one-cycle ack to the claimed source
    always_comb begin
        for (int i = 0; i < IRQ_CNT; i++) begin
            iack_o[i] = (state_q == ST_ACK) && (claim_id == irq_id_t'(i + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (ofs)
                OFS_IRQ_ENABLE:  rdata_o <= 32'(irq_en);
                OFS_IRQ_PENDING: rdata_o <= 32'(irq_i);
                OFS_IRQ_CLAIM:   rdata_o <= 32'(claim_id);   // zero when idle
                default:         rdata_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/rtc_timer.sv ====
`default_nettype none

module rtc_timer
    import platform_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        en_i,
    input  bus_req_t    req_i,
    output logic [31:0] rdata_o,
    output logic        mti_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [3:0]  ofs;
    logic        wr;

    assign ofs = req_i.addr[3:0];
    assign wr  = en_i && (req_i.we != '0);

    // replace only the strobed bytes
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0]  we
    );
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;   // writes are ignored
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtimecmp <= '1;
        end else if (wr && ofs == OFS_MTIMECMP_LO) begin
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], req_i.wdata, req_i.we);
        end else if (wr && ofs == OFS_MTIMECMP_HI) begin
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req_i.wdata, req_i.we);
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (ofs)
                OFS_MTIME_LO:    rdata_o <= mtime[31:0];
                OFS_MTIME_HI:    rdata_o <= mtime[63:32];
                OFS_MTIMECMP_LO: rdata_o <= mtimecmp[31:0];
                OFS_MTIMECMP_HI: rdata_o <= mtimecmp[63:32];
                default:         rdata_o <= '0;
            endcase
        end
    end

    assign mti_o = (mtime >= mtimecmp);   // level, no latch

endmodule

`default_nettype wire

// ==== project.f ====
design/platform_pkg.sv
design/irq_pkg.sv
design/bus_fabric.sv
design/rtc_timer.sv
design/plic_gateway.sv
design/pin_port.sv
design/platform_top.sv
test/platform_checker.sv
test/tb_platform.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the platform testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_platform \
    -f project.f \
    -o sim_platform

./obj_dir/sim_platform | tee "$LOG"

if grep -q "Simulation PASSED" "$LOG"; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

// ==== test/platform_checker.sv ====
`default_nettype none

module platform_checker
    import platform_pkg::*, irq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n_i,
    // DUT outputs
    input  logic [31:0]          rdata_i,
    input  irq_lines_t           irq_i,
    input  logic [PIN_OUT_W-1:0] leds_i,
    // expectations from the model
    input  logic                 exp_rdata_v_i,
    input  logic [31:0]          exp_rdata_i,
    input  logic                 exp_mti_i,
    input  logic                 exp_mei_v_i,
    input  logic                 exp_mei_i,
    input  logic [PIN_OUT_W-1:0] exp_leds_i,
    output int                   err_cnt_o
);

    int chk_cnt  = 0;
    int err_cnt  = 0;
    int test_cnt = 0;
    int fail_cnt = 0;
    int err_mark = 0;   // err_cnt at the end of the last test

    assign err_cnt_o = err_cnt;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp, act);
        end
    endtask

    ////////////////////
    // sampling
    ////////////////////

    // values seen here were stable over the whole cycle before the edge
    always @(posedge clk) begin
        if (rst_n_i) begin
            compare("irq_o.mti", 32'(exp_mti_i), 32'(irq_i.mti));   // every cycle
            compare("leds_o", 32'(exp_leds_i), 32'(leds_i));
            if (exp_rdata_v_i) begin
                compare("bus_rdata_o", exp_rdata_i, rdata_i);
            end
            if (exp_mei_v_i) begin
                compare("irq_o.mei", 32'(exp_mei_i), 32'(irq_i.mei));
            end
        end
    end

    task automatic close_test(input string name);
        int n;
        n = err_cnt - err_mark;
        err_mark = err_cnt;
        test_cnt++;
        if (n == 0) begin
            $display("[%0t] test %s: ok", $time, name);
        end else begin
            fail_cnt++;
            $display("[%0t] test %s: %0d mismatches", $time, name, n);
        end
    endtask

    task automatic summary();
        $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
                 test_cnt, fail_cnt, chk_cnt, err_cnt);
    endtask

endmodule

`default_nettype wire

// ==== test/tb_platform.sv ====
`default_nettype none

module tb_platform
    import platform_pkg::*, irq_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int T_MTIME    = 80;   // rough cycle budget per test
    localparam int T_CMP      = 60;
    localparam int T_LEDS     = 60;
    localparam int T_PINS     = 80;
    localparam int T_CLAIM    = 80;
    localparam int RUN_CYCLES = T_MTIME + T_CMP + T_LEDS + T_PINS + T_CLAIM + 100;

    logic                 clk;
    logic                 rst_n;
    bus_req_t             bus_req;
    logic [31:0]          bus_rdata;
    logic                 irq_ack;
    irq_vec_t             pins;
    logic [PIN_OUT_W-1:0] leds;
    irq_lines_t           irq_lines;

    logic                 exp_rdata_v;
    logic [31:0]          exp_rdata;
    logic                 exp_mei_v;
    logic                 exp_mei;
    int                   err_cnt;

    // reference model
    logic [63:0]          m_time;
    logic [63:0]          m_cmp;
    irq_vec_t             m_mask;
    irq_vec_t             m_req;    // sticky pin requests
    logic [PIN_OUT_W-1:0] m_leds;
    irq_id_t              m_claim;  // 0 while idle
    logic [31:0]          lfsr;

    platform_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .bus_req_i   (bus_req),
        .bus_rdata_o (bus_rdata),
        .irq_ack_i   (irq_ack),
        .pins_i      (pins),
        .leds_o      (leds),
        .irq_o       (irq_lines)
    );

    platform_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .rdata_i       (bus_rdata),
        .irq_i         (irq_lines),
        .leds_i        (leds),
        .exp_rdata_v_i (exp_rdata_v),
        .exp_rdata_i   (exp_rdata),
        .exp_mti_i     (m_time >= m_cmp),
        .exp_mei_v_i   (exp_mei_v),
        .exp_mei_i     (exp_mei),
        .exp_leds_i    (m_leds),
        .err_cnt_o     (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * RUN_CYCLES);
        $display("watchdog expired after %0d cycles, the tests did not finish", RUN_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_time <= '0;
        end else begin
            m_time <= m_time + 64'd1;   // one tick per clock
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [3:0] ofs);
        return {region, 24'h0, ofs};
    endfunction

    function automatic logic [31:0] byte_update(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  we);
        logic [31:0] mask;
        mask = {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic irq_id_t lowest_id(input irq_vec_t v);
        irq_id_t id;
        id = '0;
        for (int i = 0; i < IRQ_CNT; i++) begin
            if (v[i] && id == '0) begin
                id = irq_id_t'(i + 1);
            end
        end
        return id;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [3:0] we,
                               input logic [31:0] data);
        logic [3:0] region;
        logic [3:0] ofs;
        region = addr[31:28];
        ofs = addr[3:0];
        if (we == '0 || region < REGION_RTC) begin
            return;   // a read or program memory
        end
        if (region < REGION_PLIC_LO) begin
            if (ofs == OFS_MTIMECMP_LO) begin
                m_cmp[31:0] = byte_update(m_cmp[31:0], data, we);
            end else if (ofs == OFS_MTIMECMP_HI) begin
                m_cmp[63:32] = byte_update(m_cmp[63:32], data, we);
            end
        end else if (region < REGION_PERIPH_LO) begin
            if (ofs == OFS_IRQ_ENABLE && we[0]) begin
                m_mask = data[IRQ_CNT-1:0];
            end else if (ofs == OFS_IRQ_CLAIM && m_claim != '0 && data == 32'(m_claim)) begin
                m_claim = '0;
            end
        end else if (ofs == OFS_PIN_OUT && we[0]) begin
            m_leds = data[PIN_OUT_W-1:0];
        end
    endtask

    // all bus tasks start and end just after a falling edge
    task automatic bus_write(input logic [31:0] addr, input logic [3:0] we,
                             input logic [31:0] data);
        bus_req = '{en: 1'b1, we: we, addr: addr, wdata: data};
        @(negedge clk);
        bus_req = '0;
        model_write(addr, we, data);   // DUT took it on the last rising edge
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
        bus_req = '{en: 1'b1, we: 4'h0, addr: addr, wdata: 32'h0};
        @(negedge clk);
        bus_req = '0;
        exp_rdata = exp;
        exp_rdata_v = 1'b1;
        @(negedge clk);
        exp_rdata_v = 1'b0;
    endtask

    task automatic expect_mei(input logic level);
        exp_mei = level;
        exp_mei_v = 1'b1;
        @(negedge clk);
        exp_mei_v = 1'b0;
    endtask

    ////////////////////
    // tests
    ////////////////////

    initial begin
        int          gap;
        logic [63:0] t0;
        logic [63:0] target;
        logic [31:0] data;
        logic [3:0]  we;
        logic [3:0]  region;
        irq_vec_t    rise;
        irq_id_t     id;

        lfsr = 32'h3064efcc;
        rst_n = 1'b0;
        bus_req = '0;
        irq_ack = 1'b0;
        pins = '0;
        exp_rdata_v = 1'b0;
        exp_rdata = '0;
        exp_mei_v = 1'b0;
        exp_mei = 1'b0;
        m_cmp = '1;
        m_mask = '0;
        m_req = '0;
        m_leds = '0;
        m_claim = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // mtime reads a random distance apart
        gap = 2 + int'(rnd(6));
        t0 = m_time;
        bus_read(reg_addr(REGION_RTC, OFS_MTIME_LO), t0[31:0]);
        repeat (gap - 2) @(negedge clk);
        bus_read(reg_addr(REGION_RTC, OFS_MTIME_LO), t0[31:0] + 32'(gap));
        bus_read(reg_addr(REGION_RTC, OFS_MTIME_HI), m_time[63:32]);
        u_checker.close_test("mtime");

        // compare register a few counts ahead of mtime
        target = m_time + 64'(16 + rnd(4));
        bus_write(reg_addr(REGION_RTC, OFS_MTIMECMP_HI), 4'hf, target[63:32]);
        bus_write(reg_addr(REGION_RTC, OFS_MTIMECMP_LO), 4'b0101, target[31:0]);
        bus_read(reg_addr(REGION_RTC, OFS_MTIMECMP_LO), m_cmp[31:0]);
        bus_write(reg_addr(REGION_RTC, OFS_MTIMECMP_LO), 4'b1010, target[31:0]);
        bus_read(reg_addr(REGION_RTC, OFS_MTIMECMP_LO), target[31:0]);
        while (m_time <= target + 64'd3) @(negedge clk);
        bus_write(reg_addr(REGION_RTC, OFS_MTIMECMP_LO), 4'hf, 32'hffff_ffff);
        bus_write(reg_addr(REGION_RTC, OFS_MTIMECMP_HI), 4'hf, 32'hffff_ffff);
        repeat (2) @(negedge clk);
        u_checker.close_test("mtimecmp");

        // output register with random strobes and a program memory access
        repeat (8) begin
            region = 4'(8 + rnd(3));
            data = rnd(32);
            we = 4'(rnd(4));
            bus_write(reg_addr(region, OFS_PIN_OUT), we, data);
            bus_read(reg_addr(REGION_PERIPH_LO, OFS_PIN_OUT), 32'(m_leds));
        end
        region = 4'(rnd(1));
        data = rnd(24);
        bus_write({region, data[23:0], OFS_PIN_OUT}, 4'hf, ~32'(m_leds));   // goes nowhere
        bus_read({region, data[23:0], OFS_PIN_OUT}, 32'h0);
        bus_read(reg_addr(REGION_PERIPH_LO, OFS_PIN_OUT), 32'(m_leds));
        u_checker.close_test("leds");

        // pin edges into requests and pending
        repeat (4) begin
            rise = irq_vec_t'(rnd(IRQ_CNT));
            pins = '0;
            repeat (4) @(negedge clk);
            pins = rise;
            m_req = m_req | rise;
            repeat (5) @(negedge clk);   // synchronizer plus edge detect
            region = 4'(3 + rnd(2));
            bus_write(reg_addr(region, OFS_IRQ_ENABLE), 4'hf, 32'(rnd(IRQ_CNT)));
            bus_read(reg_addr(REGION_PERIPH_LO, OFS_PIN_REQ), 32'(m_req));
            bus_read(reg_addr(region, OFS_IRQ_PENDING), 32'(m_req));
            expect_mei((m_req & m_mask) != '0);
        end
        u_checker.close_test("pins");

        // claim and complete in source order
        pins = '0;
        repeat (4) @(negedge clk);
        pins = '1;
        m_req = '1;
        repeat (5) @(negedge clk);
        bus_write(reg_addr(REGION_PLIC_LO, OFS_IRQ_ENABLE), 4'hf, 32'h3);
        repeat (IRQ_CNT + 1) begin
            id = lowest_id(m_req & m_mask);
            irq_ack = 1'b1;
            @(negedge clk);
            irq_ack = 1'b0;
            if (id != '0) begin
                m_claim = id;
                m_req = m_req & ~(irq_vec_t'(1) << (id - 1));
            end
            @(negedge clk);
            bus_read(reg_addr(REGION_PLIC_LO, OFS_IRQ_CLAIM), 32'(m_claim));
            bus_read(reg_addr(REGION_PERIPH_LO, OFS_PIN_REQ), 32'(m_req));
            expect_mei(1'b0);
            if (id != '0) begin
                bus_write(reg_addr(REGION_PLIC_LO, OFS_IRQ_CLAIM), 4'hf, 32'(id ^ 2'b11));
                expect_mei(1'b0);   // wrong id leaves the claim open
                bus_write(reg_addr(REGION_PLIC_LO, OFS_IRQ_CLAIM), 4'hf, 32'(id));
                expect_mei((m_req & m_mask) != '0);
            end
        end
        u_checker.close_test("claim");

        u_checker.summary();
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
